/* common/decode_pkg.sv */
package decode_pkg;

    localparam int xlen = 32;
    localparam int reg_addr_width = 5;
    localparam int num_read_ports = 2;

    // Machine exception codes.
    localparam logic [3:0] cause_illegal = 4'd2;
    localparam logic [3:0] cause_breakpoint = 4'd3;
    localparam logic [3:0] cause_load_misaligned = 4'd4;
    localparam logic [3:0] cause_store_misaligned = 4'd6;
    localparam logic [3:0] cause_ecall_m = 4'd11;

    typedef struct packed {
        logic [6:0] funct7;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] rd;
        logic [6:0] opcode;
    } r_fmt_t;

    typedef struct packed {
        logic [11:0] imm_11_0;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] rd;
        logic [6:0] opcode;
    } i_fmt_t;

    typedef struct packed {
        logic [6:0] imm_11_5;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] imm_4_0;
        logic [6:0] opcode;
    } s_fmt_t;

    typedef struct packed {
        logic imm_12;
        logic [5:0] imm_10_5;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [3:0] imm_4_1;
        logic imm_11;
        logic [6:0] opcode;
    } b_fmt_t;

    typedef struct packed {
        logic [19:0] imm_31_12;
        logic [4:0] rd;
        logic [6:0] opcode;
    } u_fmt_t;

    typedef struct packed {
        logic imm_20;
        logic [9:0] imm_10_1;
        logic imm_11;
        logic [7:0] imm_19_12;
        logic [4:0] rd;
        logic [6:0] opcode;
    } j_fmt_t;

    // One fetched word, seen through every base format.
    typedef union packed {
        logic [31:0] raw;
        r_fmt_t r_fmt;
        i_fmt_t i_fmt;
        s_fmt_t s_fmt;
        b_fmt_t b_fmt;
        u_fmt_t u_fmt;
        j_fmt_t j_fmt;
    } instr_word_t;

    typedef enum logic [3:0] {
        alu_add, alu_sub, alu_sll, alu_slt, alu_sltu,
        alu_xor, alu_srl, alu_sra, alu_or, alu_and
    } alu_op_t;

    // Encodings follow funct3 of the branch and load/store opcodes.
    typedef enum logic [2:0] {
        bcu_beq = 3'd0, bcu_bne = 3'd1, bcu_blt = 3'd4,
        bcu_bge = 3'd5, bcu_bltu = 3'd6, bcu_bgeu = 3'd7
    } bcu_op_t;

    typedef enum logic [2:0] {
        lsu_b = 3'd0, lsu_h = 3'd1, lsu_w = 3'd2, lsu_bu = 3'd4, lsu_hu = 3'd5
    } lsu_op_t;

    typedef struct packed {
        logic valid;
        logic [xlen-1:0] pc;
        instr_word_t instr;
    } fetch_t;

    typedef struct packed {
        logic wren;
        logic [reg_addr_width-1:0] waddr;
        logic [xlen-1:0] wdata;
    } wb_t;

    typedef struct packed {
        logic valid;
        logic [xlen-1:0] imm;
        logic [reg_addr_width-1:0] waddr;
        logic [reg_addr_width-1:0] raddr1;
        logic [reg_addr_width-1:0] raddr2;
        logic wren;
        logic rden1;
        logic rden2;
        logic lui;
        logic auipc;
        logic jal;
        logic jalr;
        logic branch;
        logic load;
        logic store;
        logic ecall;
        logic ebreak;
        alu_op_t alu_op;
        bcu_op_t bcu_op;
        lsu_op_t lsu_op;
        logic compressed;
    } ctrl_t;

    typedef struct packed {
        logic valid;
        logic [xlen-1:0] pc;
        logic [xlen-1:0] npc;
        ctrl_t ctrl;
        logic [xlen-1:0] rdata1;
        logic [xlen-1:0] rdata2;
        logic jump;
        logic [xlen-1:0] target;
        logic [xlen-1:0] address;
        logic [3:0] byteenable;
        logic exception;
        logic [3:0] ecause;
        logic [xlen-1:0] etval;
    } decoded_t;

    localparam decoded_t decoded_reset = '0;

endpackage

/* decode/compress_expander.sv */
`timescale 1ns/1ps

module compress_expander import decode_pkg::*; (
    input  logic [15:0] half,
    output logic [31:0] expanded,
    output logic        illegal
);

    logic [4:0] rd;
    logic [4:0] rs2;
    logic [4:0] rs1_p;
    logic [4:0] rd_p; // Also rs2' of c.sw.
    logic [11:0] j_off;
    logic [6:0] lw_off;
    logic [9:0] spn_imm;

    assign rd = half[11:7];
    assign rs2 = half[6:2];
    assign rs1_p = {2'b01, half[9:7]};
    assign rd_p = {2'b01, half[4:2]};
    assign j_off = {half[12], half[8], half[10:9], half[6], half[7], half[2], half[11],
                    half[5:3], 1'b0};
    assign lw_off = {half[5], half[12:10], half[6], 2'b00};
    assign spn_imm = {half[10:7], half[12:11], half[5], half[6], 2'b00};

    always_comb begin
        expanded = '0;
        illegal = 1'b0;
        case ({half[1:0], half[15:13]})
            5'b00_000: begin // c.addi4spn, zero word lands here too.
                expanded = {2'b00, spn_imm, 5'd2, 3'b000, rd_p, 7'b0010011};
                illegal = (half[12:5] == 8'd0);
            end
            5'b00_010: expanded = {5'b0, lw_off, rs1_p, 3'b010, rd_p, 7'b0000011};
            5'b00_110: expanded = {5'b0, lw_off[6:5], rd_p, rs1_p, 3'b010, lw_off[4:0],
                                   7'b0100011};
            5'b01_000: expanded = {{6{half[12]}}, half[12], half[6:2], rd, 3'b000, rd,
                                   7'b0010011};
            5'b01_001, 5'b01_101: begin // c.jal links x1, c.j links nothing.
                expanded = {j_off[11], j_off[10:1], j_off[11], {8{j_off[11]}},
                            {4'b0, ~half[15]}, 7'b1101111};
            end
            5'b01_010: expanded = {{6{half[12]}}, half[12], half[6:2], 5'd0, 3'b000, rd,
                                   7'b0010011};
            5'b01_011: begin
                expanded = {{14{half[12]}}, half[12], half[6:2], rd, 7'b0110111};
                illegal = ({half[12], half[6:2]} == 6'd0) || (rd == 5'd2); // No addi16sp.
            end
            5'b01_110, 5'b01_111: begin // c.beqz, c.bnez.
                expanded = {half[12], {3{half[12]}}, half[6:5], half[2], 5'd0, rs1_p,
                            {2'b00, half[13]}, half[11:10], half[4:3], half[12], 7'b1100011};
            end
            5'b10_100: begin
                if (!half[12]) begin
                    if (rs2 == 5'd0) begin
                        expanded = {12'd0, rd, 3'b000, 5'd0, 7'b1100111}; // c.jr
                        illegal = (rd == 5'd0);
                    end else begin
                        expanded = {7'd0, rs2, 5'd0, 3'b000, rd, 7'b0110011}; // c.mv
                    end
                end else if (rs2 == 5'd0) begin
                    if (rd == 5'd0) begin
                        expanded = 32'h0010_0073; // c.ebreak
                    end else begin
                        expanded = {12'd0, rd, 3'b000, 5'd1, 7'b1100111}; // c.jalr
                    end
                end else begin
                    expanded = {7'd0, rs2, rd, 3'b000, rd, 7'b0110011}; // c.add
                end
            end
            default: illegal = 1'b1;
        endcase
    end

endmodule

/* decode/instr_decoder.sv */
`timescale 1ns/1ps

module instr_decoder import decode_pkg::*; (
    input  instr_word_t instr,
    output ctrl_t       ctrl
);

    logic [31:0] expanded;
    logic c_illegal;
    logic is_c;
    instr_word_t w;
    logic [xlen-1:0] imm_i;
    logic [xlen-1:0] imm_s;
    logic [xlen-1:0] imm_b;
    logic [xlen-1:0] imm_u;
    logic [xlen-1:0] imm_j;

    compress_expander u_expander (
        .half    (instr.raw[15:0]),
        .expanded(expanded),
        .illegal (c_illegal)
    );

    assign is_c = (instr.raw[1:0] != 2'b11);
    assign w.raw = is_c ? expanded : instr.raw;

    assign imm_i = {{20{w.i_fmt.imm_11_0[11]}}, w.i_fmt.imm_11_0};
    assign imm_s = {{20{w.s_fmt.imm_11_5[6]}}, w.s_fmt.imm_11_5, w.s_fmt.imm_4_0};
    assign imm_b = {{20{w.b_fmt.imm_12}}, w.b_fmt.imm_11, w.b_fmt.imm_10_5,
                    w.b_fmt.imm_4_1, 1'b0};
    assign imm_u = {w.u_fmt.imm_31_12, 12'd0};
    assign imm_j = {{12{w.j_fmt.imm_20}}, w.j_fmt.imm_19_12, w.j_fmt.imm_11,
                    w.j_fmt.imm_10_1, 1'b0};

    function automatic alu_op_t alu_sel(input logic [2:0] funct3, input logic alt);
        case (funct3)
            3'b000: alu_sel = alt ? alu_sub : alu_add;
            3'b001: alu_sel = alu_sll;
            3'b010: alu_sel = alu_slt;
            3'b011: alu_sel = alu_sltu;
            3'b100: alu_sel = alu_xor;
            3'b101: alu_sel = alt ? alu_sra : alu_srl;
            3'b110: alu_sel = alu_or;
            default: alu_sel = alu_and;
        endcase
    endfunction

    always_comb begin
        ctrl = '0;
        ctrl.valid = 1'b1;
        ctrl.compressed = is_c;
        ctrl.waddr = w.r_fmt.rd;
        ctrl.raddr1 = w.r_fmt.rs1;
        ctrl.raddr2 = w.r_fmt.rs2;
        ctrl.alu_op = alu_add;
        ctrl.bcu_op = bcu_op_t'(w.b_fmt.funct3);
        ctrl.lsu_op = lsu_op_t'(w.i_fmt.funct3);
        case (w.r_fmt.opcode)
            7'b0110111: begin
                ctrl.wren = 1'b1;
                ctrl.lui = 1'b1;
                ctrl.imm = imm_u;
            end
            7'b0010111: begin
                ctrl.wren = 1'b1;
                ctrl.auipc = 1'b1;
                ctrl.imm = imm_u;
            end
            7'b1101111: begin
                ctrl.wren = 1'b1;
                ctrl.jal = 1'b1;
                ctrl.imm = imm_j;
            end
            7'b1100111: begin
                {ctrl.wren, ctrl.rden1, ctrl.jalr} = 3'b111;
                ctrl.imm = imm_i;
                ctrl.valid = (w.i_fmt.funct3 == 3'b000);
            end
            7'b1100011: begin
                {ctrl.rden1, ctrl.rden2, ctrl.branch} = 3'b111;
                ctrl.imm = imm_b;
                ctrl.valid = (w.b_fmt.funct3[2:1] != 2'b01);
            end
            7'b0000011: begin
                {ctrl.wren, ctrl.rden1, ctrl.load} = 3'b111;
                ctrl.imm = imm_i;
                ctrl.valid = (w.i_fmt.funct3 inside {3'd0, 3'd1, 3'd2, 3'd4, 3'd5});
            end
            7'b0100011: begin
                {ctrl.rden1, ctrl.rden2, ctrl.store} = 3'b111;
                ctrl.imm = imm_s;
                ctrl.valid = (w.s_fmt.funct3 inside {3'd0, 3'd1, 3'd2});
            end
            7'b0010011: begin
                {ctrl.wren, ctrl.rden1} = 2'b11;
                ctrl.imm = imm_i;
                ctrl.alu_op = alu_sel(w.r_fmt.funct3,
                                      (w.r_fmt.funct3 == 3'b101) && w.r_fmt.funct7[5]);
                if (w.r_fmt.funct3 == 3'b001) begin
                    ctrl.valid = (w.r_fmt.funct7 == 7'd0);
                end else if (w.r_fmt.funct3 == 3'b101) begin
                    ctrl.valid = (w.r_fmt.funct7 inside {7'd0, 7'b0100000});
                end
            end
            7'b0110011: begin
                {ctrl.wren, ctrl.rden1, ctrl.rden2} = 3'b111;
                ctrl.alu_op = alu_sel(w.r_fmt.funct3, w.r_fmt.funct7[5]);
                ctrl.valid = (w.r_fmt.funct7 == 7'd0) || (w.r_fmt.funct7 == 7'b0100000 &&
                             w.r_fmt.funct3 inside {3'b000, 3'b101});
            end
            7'b1110011: begin // Only ecall and ebreak.
                ctrl.ecall = (w.raw == 32'h0000_0073);
                ctrl.ebreak = (w.raw == 32'h0010_0073);
                ctrl.valid = ctrl.ecall | ctrl.ebreak;
            end
            default: ctrl.valid = 1'b0;
        endcase
        if (is_c && c_illegal) ctrl.valid = 1'b0;
    end

endmodule

/* decode/decode_stage.sv */
`timescale 1ns/1ps

module decode_stage import decode_pkg::*; (
    input  logic            clk,
    input  logic            rst,
    input  fetch_t          fetch,
    input  ctrl_t           ctrl,
    input  logic [xlen-1:0] rdata1,
    input  logic [xlen-1:0] rdata2,
    input  logic            hold,
    input  logic            flush,
    output decoded_t        q
);

    decoded_t v;
    logic taken;
    logic misaligned;
    logic [xlen-1:0] rs1_sum;

    assign rs1_sum = rdata1 + ctrl.imm;

    always_comb begin
        case (ctrl.bcu_op)
            bcu_beq: taken = (rdata1 == rdata2);
            bcu_bne: taken = (rdata1 != rdata2);
            bcu_blt: taken = ($signed(rdata1) < $signed(rdata2));
            bcu_bge: taken = ($signed(rdata1) >= $signed(rdata2));
            bcu_bltu: taken = (rdata1 < rdata2);
            bcu_bgeu: taken = (rdata1 >= rdata2);
            default: taken = 1'b0;
        endcase
    end

    always_comb begin
        v = decoded_reset;
        v.valid = 1'b1;
        v.pc = fetch.pc;
        v.npc = fetch.pc + (ctrl.compressed ? 32'd2 : 32'd4);
        v.ctrl = ctrl;
        v.rdata1 = rdata1;
        v.rdata2 = rdata2;
        v.jump = ctrl.jal | ctrl.jalr | (ctrl.branch & taken);
        v.target = ctrl.jalr ? {rs1_sum[xlen-1:1], 1'b0} : fetch.pc + ctrl.imm;
        v.address = rs1_sum;

        case (ctrl.lsu_op)
            lsu_b, lsu_bu: begin
                v.byteenable = 4'b0001 << rs1_sum[1:0];
                misaligned = 1'b0;
            end
            lsu_h, lsu_hu: begin
                v.byteenable = 4'b0011 << {rs1_sum[1], 1'b0};
                misaligned = rs1_sum[0];
            end
            default: begin
                v.byteenable = 4'b1111;
                misaligned = (rs1_sum[1:0] != 2'b00);
            end
        endcase
        if (!(ctrl.load | ctrl.store)) v.byteenable = 4'b0000;

        if (!ctrl.valid) begin
            v.exception = 1'b1;
            v.ecause = cause_illegal;
            v.etval = ctrl.compressed ? {16'd0, fetch.instr.raw[15:0]} : fetch.instr.raw;
        end else if (ctrl.ebreak) begin
            v.exception = 1'b1;
            v.ecause = cause_breakpoint;
            v.etval = fetch.pc;
        end else if (ctrl.ecall) begin
            v.exception = 1'b1;
            v.ecause = cause_ecall_m;
        end else if (ctrl.load && misaligned) begin
            v.exception = 1'b1;
            v.ecause = cause_load_misaligned;
            v.etval = rs1_sum;
        end else if (ctrl.store && misaligned) begin
            v.exception = 1'b1;
            v.ecause = cause_store_misaligned;
            v.etval = rs1_sum;
        end

        if (v.exception) begin // Nothing retires or redirects.
            v.ctrl.wren = 1'b0;
            v.jump = 1'b0;
            v.byteenable = 4'b0000;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst) begin
            q <= decoded_reset;
        end else if (flush) begin
            q <= decoded_reset; // Wins over hold.
        end else if (!hold) begin
            q <= fetch.valid ? v : decoded_reset;
        end
    end

    a_jump_no_exc: assert property (@(posedge clk) disable iff (!rst)
        !(q.jump && q.exception))
        else $error("jump and exception both set");

    a_jump_valid: assert property (@(posedge clk) disable iff (!rst)
        q.jump |-> q.valid)
        else $error("jump on an invalid packet");

endmodule

/* logic/operand_fetch.sv */
`timescale 1ns/1ps

module operand_fetch import decode_pkg::*; (
    input  logic                      rden,
    input  logic [reg_addr_width-1:0] raddr,
    input  logic [xlen-1:0]           rf_data,
    input  wb_t                       wb,
    output logic [xlen-1:0]           data
);

    logic hit;

    // Writeback in the same cycle bypasses the array.
    assign hit = wb.wren && (wb.waddr == raddr);

    always_comb begin
        if (!rden || raddr == '0) begin
            data = '0;
        end else if (hit) begin
            data = wb.wdata;
        end else begin
            data = rf_data;
        end
    end

endmodule

/* logic/register_file.sv */
`timescale 1ns/1ps

module register_file import decode_pkg::*; (
    input  logic                      clk,
    input  logic                      rst,
    input  wb_t                       wb,
    input  logic [reg_addr_width-1:0] raddr [num_read_ports],
    output logic [xlen-1:0]           rdata [num_read_ports]
);

    logic [xlen-1:0] regs [1:31]; // No storage for x0.

    always_ff @(posedge clk) begin
        if (rst && wb.wren && wb.waddr != '0) begin
            regs[wb.waddr] <= wb.wdata;
        end
    end

    for (genvar p = 0; p < num_read_ports; p++) begin : g_read
        assign rdata[p] = (raddr[p] == '0) ? '0 : regs[raddr[p]];
    end

    a_waddr_known: assert property (@(posedge clk) disable iff (!rst)
        wb.wren |-> !$isunknown(wb.waddr))
        else $error("write address unknown");

endmodule

/* logic/decode_top.sv */
`timescale 1ns/1ps

module decode_top import decode_pkg::*; (
    input  logic            clk,
    input  logic            rst,
    input  fetch_t          fetch,
    input  wb_t             wb,
    input  logic            hold,
    input  logic            flush,
    output decoded_t        q,
    output logic            redirect_valid,
    output logic [xlen-1:0] redirect_pc
);

    ctrl_t ctrl;
    logic [reg_addr_width-1:0] raddr [num_read_ports];
    logic rden [num_read_ports];
    logic [xlen-1:0] rf_data [num_read_ports];
    logic [xlen-1:0] opnd [num_read_ports];

    assign raddr[0] = ctrl.raddr1;
    assign raddr[1] = ctrl.raddr2;
    assign rden[0] = ctrl.rden1;
    assign rden[1] = ctrl.rden2;

    register_file u_regs (
        .clk  (clk),
        .rst  (rst),
        .wb   (wb),
        .raddr(raddr),
        .rdata(rf_data)
    );

    instr_decoder u_decoder (
        .instr(fetch.instr),
        .ctrl (ctrl)
    );

    for (genvar i = 0; i < num_read_ports; i++) begin : g_port
        operand_fetch u_opnd (
            .rden   (rden[i]),
            .raddr  (raddr[i]),
            .rf_data(rf_data[i]),
            .wb     (wb),
            .data   (opnd[i])
        );
    end

    decode_stage u_stage (
        .clk   (clk),
        .rst   (rst),
        .fetch (fetch),
        .ctrl  (ctrl),
        .rdata1(opnd[0]),
        .rdata2(opnd[1]),
        .hold  (hold),
        .flush (flush),
        .q     (q)
    );

    assign redirect_valid = q.jump;
    assign redirect_pc = q.target;

endmodule

/* sim/decode_checker.sv */
`timescale 1ns/1ps

module decode_checker import decode_pkg::*; (
    input  logic            clk,
    input  logic            check_en,
    input  logic [95:0]     name,
    input  decoded_t        exp,
    input  logic            full,
    input  decoded_t        q,
    input  logic            redirect_valid,
    input  logic [xlen-1:0] redirect_pc,
    output int              n_tests,
    output int              n_errors
);

    int bad;

    initial begin
        n_tests = 0;
        n_errors = 0;
    end

    task automatic check_word(input string field, input logic [31:0] e, input logic [31:0] a);
        if (e !== a) begin
            $display("FAIL %0s %0s expected %h actual %h", name, field, e, a);
            bad++;
        end
    endtask

    // Registered outputs are stable at the falling edge.
    always @(negedge clk) begin
        if (check_en) begin
            bad = 0;
            check_word("valid", 32'(exp.valid), 32'(q.valid));
            check_word("jump", 32'(exp.jump), 32'(q.jump));
            check_word("redirect_valid", 32'(exp.jump), 32'(redirect_valid));
            check_word("exception", 32'(exp.exception), 32'(q.exception));
            check_word("pc", exp.pc, q.pc);
            if (exp.exception) begin
                check_word("ecause", 32'(exp.ecause), 32'(q.ecause));
                check_word("etval", exp.etval, q.etval);
            end
            if (exp.jump) begin
                check_word("redirect_pc", exp.target, redirect_pc);
            end
            if (full) begin
                check_word("npc", exp.npc, q.npc);
                check_word("imm", exp.ctrl.imm, q.ctrl.imm);
                if (exp.ctrl.waddr != '0) begin // Only where a register is written.
                    check_word("waddr", 32'(exp.ctrl.waddr), 32'(q.ctrl.waddr));
                end
                check_word("rdata1", exp.rdata1, q.rdata1);
                check_word("rdata2", exp.rdata2, q.rdata2);
                check_word("target", exp.target, q.target);
                check_word("address", exp.address, q.address);
                check_word("byteenable", 32'(exp.byteenable), 32'(q.byteenable));
            end
            n_tests++;
            if (bad == 0) begin
                $display("PASS %0s", name);
            end else begin
                n_errors++;
            end
        end
    end

endmodule

/* sim/tb_decode.sv */
`timescale 1ns/1ps

module tb_decode import decode_pkg::*; ();

    localparam int max_rows = 40;
    localparam int period = 40;

    logic clk;
    logic rst;
    fetch_t fetch;
    wb_t wb;
    logic hold;
    logic flush;
    decoded_t q;
    logic redirect_valid;
    logic [xlen-1:0] redirect_pc;

    logic check_en;
    logic [95:0] check_name;
    decoded_t check_exp;
    logic check_full;
    int n_tests;
    int n_errors;

    // Stimulus and expected values, one entry per test.
    logic [95:0] name_tab [max_rows];
    logic [31:0] pc_tab [max_rows];
    logic [31:0] instr_tab [max_rows];
    logic valid_tab [max_rows];
    wb_t wb_tab [max_rows];
    logic hold_tab [max_rows];
    logic flush_tab [max_rows];
    logic full_tab [max_rows];
    decoded_t exp_tab [max_rows];
    int n_rows;

    logic [31:0] shadow [32];
    logic [4:0] pre_addr [8];
    logic [31:0] pre_data [8];
    wb_t cur_wb;
    logic cur_hold;
    logic cur_flush;
    logic cur_valid;

    decode_top u_dut (
        .clk(clk), .rst(rst), .fetch(fetch), .wb(wb), .hold(hold), .flush(flush),
        .q(q), .redirect_valid(redirect_valid), .redirect_pc(redirect_pc)
    );

    decode_checker u_checker (
        .clk(clk), .check_en(check_en), .name(check_name), .exp(check_exp),
        .full(check_full), .q(q), .redirect_valid(redirect_valid),
        .redirect_pc(redirect_pc), .n_tests(n_tests), .n_errors(n_errors)
    );

    initial begin
        clk = 1'b0;
        forever #(period / 2) clk = ~clk;
    end

    // RV32I base encodings.
    function automatic logic [31:0] enc_r(input logic [6:0] f7, input logic [4:0] rs2,
            input logic [4:0] rs1, input logic [2:0] f3, input logic [4:0] rd);
        enc_r = {f7, rs2, rs1, f3, rd, 7'h33};
    endfunction

    function automatic logic [31:0] enc_i(input logic [11:0] imm, input logic [4:0] rs1,
            input logic [2:0] f3, input logic [4:0] rd, input logic [6:0] op);
        enc_i = {imm, rs1, f3, rd, op};
    endfunction

    function automatic logic [31:0] enc_s(input logic [11:0] imm, input logic [4:0] rs2,
            input logic [4:0] rs1, input logic [2:0] f3);
        enc_s = {imm[11:5], rs2, rs1, f3, imm[4:0], 7'h23};
    endfunction

    function automatic logic [31:0] enc_b(input logic [12:0] imm, input logic [4:0] rs2,
            input logic [4:0] rs1, input logic [2:0] f3);
        enc_b = {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], 7'h63};
    endfunction

    function automatic logic [31:0] enc_j(input logic [20:0] imm, input logic [4:0] rd);
        enc_j = {imm[20], imm[10:1], imm[11], imm[19:12], rd, 7'h6f};
    endfunction

    task automatic push_row(input logic [95:0] nm, input logic [31:0] pc,
            input logic [31:0] ins, input logic full, input decoded_t e);
        name_tab[n_rows] = nm;
        pc_tab[n_rows] = pc;
        instr_tab[n_rows] = ins;
        valid_tab[n_rows] = cur_valid;
        wb_tab[n_rows] = cur_wb;
        hold_tab[n_rows] = cur_hold;
        flush_tab[n_rows] = cur_flush;
        full_tab[n_rows] = full;
        exp_tab[n_rows] = e;
        n_rows++;
        cur_wb = '0;
        cur_hold = 1'b0;
        cur_flush = 1'b0;
        cur_valid = 1'b1;
    endtask

    // Address is rs1 plus imm and npc is pc plus the instruction size.
    task automatic add_row(input logic [95:0] nm, input logic [31:0] pc,
            input logic [31:0] ins, input logic [31:0] imm, input logic [31:0] r1,
            input logic [31:0] r2, input logic jmp, input logic [31:0] tgt,
            input logic [3:0] be, input int step, input logic [4:0] rd);
        decoded_t e;
        e = '0;
        e.valid = 1'b1;
        e.pc = pc;
        e.npc = pc + step;
        e.ctrl.imm = imm;
        e.ctrl.waddr = rd;
        e.rdata1 = r1;
        e.rdata2 = r2;
        e.jump = jmp;
        e.target = tgt;
        e.address = r1 + imm;
        e.byteenable = be;
        push_row(nm, pc, ins, 1'b1, e);
    endtask

    task automatic add_exc(input logic [95:0] nm, input logic [31:0] pc,
            input logic [31:0] ins, input logic [3:0] cause, input logic [31:0] tval);
        decoded_t e;
        e = '0;
        e.valid = 1'b1;
        e.pc = pc;
        e.exception = 1'b1;
        e.ecause = cause;
        e.etval = tval;
        push_row(nm, pc, ins, 1'b0, e);
    endtask

    task automatic build_table();
        logic [31:0] nv;
        add_row("add", 32'h100, enc_r(7'd0, 5'd6, 5'd5, 3'd0, 5'd7), 32'd0, shadow[5],
                shadow[6], 1'b0, 32'h100, 4'b0000, 4, 5'd7);
        add_row("addi", 32'h104, enc_i(12'hff0, 5'd2, 3'd0, 5'd7, 7'h13), 32'hffff_fff0,
                shadow[2], 32'd0, 1'b0, 32'hf4, 4'b0000, 4, 5'd7);
        add_row("lw", 32'h108, enc_i(12'd8, 5'd8, 3'd2, 5'd7, 7'h03), 32'd8, shadow[8],
                32'd0, 1'b0, 32'h110, 4'b1111, 4, 5'd7);
        add_row("lb", 32'h10c, enc_i(12'd1, 5'd8, 3'd0, 5'd7, 7'h03), 32'd1, shadow[8],
                32'd0, 1'b0, 32'h10d, 4'b0010, 4, 5'd7);
        add_row("sw", 32'h110, enc_s(12'd4, 5'd6, 5'd8, 3'd2), 32'd4, shadow[8],
                shadow[6], 1'b0, 32'h114, 4'b1111, 4, 5'd0);
        add_row("sh", 32'h114, enc_s(12'd0, 5'd6, 5'd9, 3'd1), 32'd0, shadow[9],
                shadow[6], 1'b0, 32'h114, 4'b1100, 4, 5'd0);
        add_row("c_addi", 32'h118, {16'h0, 3'b000, 1'b0, 5'd10, 5'd3, 2'b01}, 32'd3,
                shadow[10], 32'd0, 1'b0, 32'h11b, 4'b0000, 2, 5'd10);
        add_row("c_lw", 32'h11a, {16'h0, 3'b010, 3'b000, 3'b000, 2'b10, 3'b001, 2'b00},
                32'd4, shadow[8], 32'd0, 1'b0, 32'h11e, 4'b1111, 2, 5'd9);
        add_row("c_mv", 32'h11c, {16'h0, 4'b1000, 5'd7, 5'd5, 2'b10}, 32'd0, 32'd0,
                shadow[5], 1'b0, 32'h11c, 4'b0000, 2, 5'd7);
        nv = $urandom;
        shadow[5] = nv;
        cur_wb = {1'b1, 5'd5, nv}; // Same-cycle writeback.
        add_row("fwd", 32'h120, enc_r(7'd0, 5'd6, 5'd5, 3'd0, 5'd7), 32'd0, nv,
                shadow[6], 1'b0, 32'h120, 4'b0000, 4, 5'd7);
        cur_wb = {1'b1, 5'd0, 32'hdead_beef};
        add_row("x0_read", 32'h124, enc_r(7'd0, 5'd0, 5'd0, 3'd0, 5'd7), 32'd0, 32'd0,
                32'd0, 1'b0, 32'h124, 4'b0000, 4, 5'd7);
        add_row("beq_t", 32'h200, enc_b(13'd16, 5'd11, 5'd11, 3'd0), 32'd16, shadow[11],
                shadow[11], 1'b1, 32'h210, 4'b0000, 4, 5'd0);
        add_row("bne_nt", 32'h204, enc_b(13'd16, 5'd11, 5'd11, 3'd1), 32'd16, shadow[11],
                shadow[11], 1'b0, 32'h214, 4'b0000, 4, 5'd0);
        add_row("blt_t", 32'h300, enc_b(13'h1ff8, 5'd11, 5'd10, 3'd4), 32'hffff_fff8,
                shadow[10], shadow[11], 1'b1, 32'h2f8, 4'b0000, 4, 5'd0);
        add_row("bltu_nt", 32'h304, enc_b(13'h1ff8, 5'd11, 5'd10, 3'd6), 32'hffff_fff8,
                shadow[10], shadow[11], 1'b0, 32'h2fc, 4'b0000, 4, 5'd0);
        add_row("jal", 32'h400, enc_j(21'h800, 5'd1), 32'h800, 32'd0, 32'd0, 1'b1,
                32'hc00, 4'b0000, 4, 5'd1);
        add_row("jalr", 32'h500, enc_i(12'd5, 5'd2, 3'd0, 5'd1, 7'h67), 32'd5, shadow[2],
                32'd0, 1'b1, 32'h1004, 4'b0000, 4, 5'd1);
        add_row("c_jr", 32'h600, {16'h0, 4'b1000, 5'd1, 5'd0, 2'b10}, 32'd0, shadow[1],
                32'd0, 1'b1, shadow[1], 4'b0000, 2, 5'd0);
        add_exc("illegal", 32'h700, 32'hffff_ffff, cause_illegal, 32'hffff_ffff);
        add_exc("c_illegal", 32'h704, 32'h0, cause_illegal, 32'h0);
        add_exc("ebreak", 32'h708, 32'h0010_0073, cause_breakpoint, 32'h708);
        add_exc("ecall", 32'h70c, 32'h0000_0073, cause_ecall_m, 32'h0);
        add_exc("lw_misal", 32'h710, enc_i(12'd0, 5'd9, 3'd2, 5'd7, 7'h03),
                cause_load_misaligned, shadow[9]);
        add_exc("sw_misal", 32'h714, enc_s(12'd1, 5'd6, 5'd8, 3'd2),
                cause_store_misaligned, shadow[8] + 32'd1);
        cur_hold = 1'b1;
        cur_wb = {1'b1, 5'd8, 32'h3001}; // New rs1 would move the held address.
        shadow[8] = 32'h3001;
        push_row("hold", 32'h714, instr_tab[n_rows-1], full_tab[n_rows-1],
                 exp_tab[n_rows-1]);
        cur_hold = 1'b1;
        cur_flush = 1'b1;
        push_row("flush_hold", 32'h714, instr_tab[n_rows-1], 1'b1, decoded_reset);
        cur_valid = 1'b0;
        push_row("no_fetch", 32'h800, 32'h0000_0013, 1'b1, decoded_reset);
        add_row("resume", 32'h804, enc_r(7'd0, 5'd6, 5'd5, 3'd0, 5'd7), 32'd0, shadow[5],
                shadow[6], 1'b0, 32'h804, 4'b0000, 4, 5'd7);
    endtask

    initial begin
        @(posedge rst);
        #((n_rows * 4 + 8) * period);
        $display("Timeout: the test sequence did not finish");
        $display("CHECKS FAILED");
        $finish;
    end

    initial begin
        rst = 1'b0;
        fetch = '0;
        wb = '0;
        hold = 1'b0;
        flush = 1'b0;
        check_en = 1'b0;
        check_name = '0;
        check_exp = '0;
        check_full = 1'b0;
        n_rows = 0;
        cur_wb = '0;
        cur_hold = 1'b0;
        cur_flush = 1'b0;
        cur_valid = 1'b1;
        void'($urandom(32'hbfdd905e));
        for (int r = 0; r < 32; r++) shadow[r] = 32'd0;
        pre_addr = '{5'd1, 5'd2, 5'd5, 5'd6, 5'd8, 5'd9, 5'd10, 5'd11};
        pre_data = '{32'h100, 32'h1000, $urandom, $urandom, 32'h2000, 32'h2002,
                     32'hffff_fffb, 32'd3};
        for (int k = 0; k < 8; k++) shadow[pre_addr[k]] = pre_data[k];
        build_table();

        repeat (4) @(posedge clk);
        rst <= 1'b1;
        for (int k = 0; k < 8; k++) begin
            @(posedge clk);
            wb <= {1'b1, pre_addr[k], pre_data[k]};
        end
        // Each edge drives a row and hands the previous row to the checker.
        for (int i = 0; i <= n_rows; i++) begin
            @(posedge clk);
            if (i < n_rows) begin
                fetch <= {valid_tab[i], pc_tab[i], instr_tab[i]};
                wb <= wb_tab[i];
                hold <= hold_tab[i];
                flush <= flush_tab[i];
            end else begin
                fetch <= '0;
                wb <= '0;
                hold <= 1'b0;
                flush <= 1'b0;
            end
            check_en <= (i > 0);
            if (i > 0) begin
                check_name <= name_tab[i-1];
                check_exp <= exp_tab[i-1];
                check_full <= full_tab[i-1];
            end
        end
        @(posedge clk);
        check_en <= 1'b0;
        @(negedge clk);

        $display("Tests run: %0d, failed: %0d", n_tests, n_errors);
        if (n_errors == 0 && n_tests == n_rows) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule

/* decode_unit.f */
common/decode_pkg.sv
decode/compress_expander.sv
decode/instr_decoder.sv
decode/decode_stage.sv
logic/operand_fetch.sv
logic/register_file.sv
logic/decode_top.sv
sim/decode_checker.sv
sim/tb_decode.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the decode stage testbench with Verilator.
cd "$(dirname "$0")" || exit 1
rm -f sim.log

verilator --binary --timing --assert -j 0 --top-module tb_decode \
    -f decode_unit.f -o sim_decode > build.log 2>&1 &&
    ./obj_dir/sim_decode > sim.log 2>&1 ||
    echo "Build or run ended with an error"

cat sim.log 2>/dev/null
grep -qx "ALL CHECKS PASSED" sim.log &&
    echo "Simulation passed" ||
    { echo "Simulation failed"; exit 1; }
